// ==== common/sudoku_params.svh ====
`ifndef SUDOKU_PARAMS_SVH
`define SUDOKU_PARAMS_SVH

// box side, 3 gives the usual 9x9 grid
`define SUDOKU_DIM 3

// idle cycles before a run counts as stalled
`define SUDOKU_STALL_LIMIT 15

// wishbone word address width
`define SUDOKU_WB_ADDR_W 8

`endif

// ==== common/grid_pkg.sv ====
`default_nettype none
`include "sudoku_params.svh"

package grid_pkg;

   localparam int DIM       = `SUDOKU_DIM;
   localparam int DIM_S     = DIM * DIM;       // values per group
   localparam int DIM_Q     = DIM_S * DIM_S;   // cells in the grid
   localparam int IDX_W     = $clog2(DIM_Q + 1);
   localparam int CNT_W     = $clog2(DIM_S + 1);
   localparam int NUM_PEERS = 2 * (DIM_S - 1) + (DIM - 1) * (DIM - 1);

   typedef logic [DIM_S-1:0] cell_mask_t;  // bit v set: digit v+1 still possible
   typedef logic [IDX_W-1:0] cell_idx_t;
   typedef logic [CNT_W-1:0] poss_cnt_t;

   typedef struct packed {
      logic      busy;
      logic      solved;
      logic      error;
      logic      stalled;
      cell_idx_t unsolved;
      cell_idx_t min_idx;
      poss_cnt_t min_poss;
   } solver_status_t;

   // exactly one candidate left
   function automatic logic is_single(cell_mask_t m);
      return (m != '0) && ((m & (m - 1'b1)) == '0);
   endfunction

   function automatic poss_cnt_t count_ones(cell_mask_t m);
      poss_cnt_t n;
      n = '0;
      for (int i = 0; i < DIM_S; i++)
         n = n + poss_cnt_t'(m[i]);
      return n;
   endfunction

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none
`include "sudoku_params.svh"

package bus_pkg;

   localparam int ADDR_W = `SUDOKU_WB_ADDR_W;
   localparam int DATA_W = 32;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   localparam logic [ADDR_W-1:0] CELL_BASE   = 8'd0;    // one word per cell
   localparam logic [ADDR_W-1:0] CTRL_ADDR   = 8'd128;
   localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'd129;

endpackage

`default_nettype wire

// ==== sudoku/sudoku_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module sudoku_cell
   import grid_pkg::*;
(
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             clr,
   input  wire                             start,
   input  wire cell_mask_t                 start_value,
   input  wire cell_mask_t [NUM_PEERS-1:0] peers,
   output cell_mask_t                      curr_value,
   output logic                            changed,
   output logic                            solved,
   output logic                            empty
);

   cell_mask_t taken;       // digits already owned by solved peers
   cell_mask_t next_value;

   always_comb
   begin
      taken = '0;
      for (int p = 0; p < NUM_PEERS; p++)
      begin
         if (is_single(peers[p]))
            taken = taken | peers[p];
      end
   end

   assign solved = is_single(curr_value);
   assign empty  = (curr_value == '0);

   // a solved cell keeps its digit, even against a clashing peer
   assign next_value = solved ? curr_value : (curr_value & ~taken);
   assign changed    = (next_value != curr_value);

   always_ff @(posedge clk)
   begin
      if (rst || clr)
         curr_value <= '1;
      else if (start)
         curr_value <= start_value;
      else
         curr_value <= next_value;
   end

endmodule

`default_nettype wire

// ==== sudoku/group_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module group_checker
   import grid_pkg::*;
(
   input  wire cell_mask_t [DIM_S-1:0] group,
   output logic                        dup
);

   poss_cnt_t cnt;

   always_comb
   begin
      dup = 1'b0;
      cnt = '0;
      for (int v = 0; v < DIM_S; v++)
      begin
         cnt = '0;
         for (int c = 0; c < DIM_S; c++)
         begin
            if (is_single(group[c]) && group[c][v])
               cnt = cnt + 1'b1;
         end
         if (cnt > 1)
            dup = 1'b1;   // same digit solved twice
      end
   end

endmodule

`default_nettype wire

// ==== sudoku/min_cell_finder.sv ====
`timescale 1ns/1ps
`default_nettype none

module min_cell_finder
   import grid_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire cell_mask_t [DIM_Q-1:0] grid,
   output cell_idx_t                  min_idx,
   output poss_cnt_t                  min_poss
);

   cell_idx_t best_idx;
   poss_cnt_t best_cnt;
   poss_cnt_t cnt;

   // best_cnt of zero means nothing found yet
   always_comb
   begin
      best_idx = '0;
      best_cnt = '0;
      cnt      = '0;
      for (int i = 0; i < DIM_Q; i++)
      begin
         cnt = count_ones(grid[i]);
         if (cnt > 1 && (best_cnt == '0 || cnt < best_cnt))
         begin
            best_idx = cell_idx_t'(i);   // strict compare keeps lowest index
            best_cnt = cnt;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         min_idx  <= '0;
         min_poss <= '0;
      end
      else
      begin
         min_idx  <= best_idx;
         min_poss <= best_cnt;
      end
   end

endmodule

`default_nettype wire

// ==== sudoku/sudoku_grid.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sudoku_params.svh"

module sudoku_grid
   import grid_pkg::*;
(
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         clr,
   input  wire                         start,
   input  wire cell_mask_t [DIM_Q-1:0] in_grid,
   output cell_mask_t [DIM_Q-1:0]      out_grid,
   output solver_status_t              status
);

   localparam int STALL_W   = $clog2(`SUDOKU_STALL_LIMIT + 1);
   localparam int BOX_PEERS = (DIM - 1) * (DIM - 1);

   wire cell_mask_t [DIM_Q-1:0] cells;
   wire [DIM_Q-1:0]             changed;
   wire [DIM_Q-1:0]             solved;
   wire [DIM_Q-1:0]             empty;
   wire cell_mask_t [DIM_S-1:0] groups [3*DIM_S];  // rows, then columns, then boxes
   wire [3*DIM_S-1:0]           dup;

   logic [STALL_W-1:0] stall_cnt;
   cell_idx_t          unsolved_cnt;
   cell_idx_t          unsolved_next;
   cell_idx_t          min_idx;
   poss_cnt_t          min_poss;
   logic               busy_q;
   logic               solved_q;
   logic               error_q;
   logic               stalled_q;
   logic               all_solved;
   logic               any_error;
   logic               stall_hit;

   for (genvar r = 0; r < DIM_S; r++)
   begin : g_r
      for (genvar c = 0; c < DIM_S; c++)
      begin : g_c
         wire cell_mask_t [NUM_PEERS-1:0] peers;

         for (genvar k = 0; k < DIM_S - 1; k++)
         begin : g_line
            assign peers[k]             = cells[r*DIM_S + ((k < c) ? k : k + 1)];
            assign peers[DIM_S - 1 + k] = cells[((k < r) ? k : k + 1)*DIM_S + c];
         end

         // box cells outside the own row and column
         for (genvar k = 0; k < BOX_PEERS; k++)
         begin : g_box
            localparam int ROFF = k / (DIM - 1);
            localparam int COFF = k % (DIM - 1);
            localparam int BR   = (r/DIM)*DIM + ROFF + ((ROFF >= r % DIM) ? 1 : 0);
            localparam int BC   = (c/DIM)*DIM + COFF + ((COFF >= c % DIM) ? 1 : 0);
            assign peers[2*(DIM_S - 1) + k] = cells[BR*DIM_S + BC];
         end

         sudoku_cell u_cell (
            .clk         (clk),
            .rst         (rst),
            .clr         (clr),
            .start       (start),
            .start_value (in_grid[r*DIM_S + c]),
            .peers       (peers),
            .curr_value  (cells[r*DIM_S + c]),
            .changed     (changed[r*DIM_S + c]),
            .solved      (solved[r*DIM_S + c]),
            .empty       (empty[r*DIM_S + c])
         );
      end
   end

   for (genvar g = 0; g < DIM_S; g++)
   begin : g_grp
      for (genvar k = 0; k < DIM_S; k++)
      begin : g_mem
         localparam int BOX_CELL = ((g/DIM)*DIM + k/DIM)*DIM_S + (g%DIM)*DIM + k%DIM;
         assign groups[g][k]           = cells[g*DIM_S + k];
         assign groups[DIM_S + g][k]   = cells[k*DIM_S + g];
         assign groups[2*DIM_S + g][k] = cells[BOX_CELL];
      end
   end

   for (genvar g = 0; g < 3*DIM_S; g++)
   begin : g_chk
      group_checker u_chk (
         .group (groups[g]),
         .dup   (dup[g])
      );
   end

   min_cell_finder u_min (
      .clk      (clk),
      .rst      (rst),
      .grid     (cells),
      .min_idx  (min_idx),
      .min_poss (min_poss)
   );

   assign all_solved = &solved;
   assign any_error  = (|dup) || (|empty);
   assign stall_hit  = (stall_cnt == STALL_W'(`SUDOKU_STALL_LIMIT));

   always_comb
   begin
      unsolved_next = '0;
      for (int i = 0; i < DIM_Q; i++)
         unsolved_next = unsolved_next + cell_idx_t'(!solved[i]);
   end

   always_ff @(posedge clk)
   begin
      if (rst || clr)
      begin
         stall_cnt    <= '0;
         unsolved_cnt <= cell_idx_t'(DIM_Q);
         busy_q       <= 1'b0;
         solved_q     <= 1'b0;
         error_q      <= 1'b0;
         stalled_q    <= 1'b0;
      end
      else
      begin
         if (start || (|changed))
            stall_cnt <= '0;
         else if (!stall_hit)
            stall_cnt <= stall_cnt + 1'b1;   // saturates at the limit
         unsolved_cnt <= start ? cell_idx_t'(DIM_Q) : unsolved_next;
         if (start)
         begin
            busy_q    <= 1'b1;
            solved_q  <= 1'b0;
            error_q   <= 1'b0;
            stalled_q <= 1'b0;
         end
         else if (busy_q && (all_solved || any_error || stall_hit))
         begin
            busy_q    <= 1'b0;
            solved_q  <= all_solved && !any_error;
            error_q   <= any_error;
            stalled_q <= stall_hit && !all_solved && !any_error;
         end
      end
   end

   assign out_grid = cells;
   assign status   = '{busy: busy_q, solved: solved_q, error: error_q, stalled: stalled_q,
                       unsolved: unsolved_cnt, min_idx: min_idx, min_poss: min_poss};

endmodule

`default_nettype wire

// ==== source/sudoku_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sudoku_wb_regs
   import grid_pkg::*;
   import bus_pkg::*;
(
   input  wire                         clk,
   input  wire                         rst,
   input  wire wb_req_t                wb_req,
   input  wire cell_mask_t [DIM_Q-1:0] out_grid,
   input  wire solver_status_t         status,
   output wb_rsp_t                     wb_rsp,
   output cell_mask_t [DIM_Q-1:0]      in_grid,
   output logic                        start,
   output logic                        clr
);

   logic              ack_q;
   logic              held;      // transfer done, waiting for stb to drop
   logic              req_new;
   logic [ADDR_W-1:0] cell_off;
   logic              cell_hit;
   logic [DATA_W-1:0] status_word;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] rd_q;

   // 0 is unknown, anything past the last digit gives an empty mask
   function automatic cell_mask_t digit_mask(poss_cnt_t digit);
      if (digit == '0)
         return '1;
      else if (digit <= DIM_S)
         return cell_mask_t'(1) << (digit - 1'b1);
      else
         return '0;
   endfunction

   assign req_new  = wb_req.cyc && wb_req.stb && !ack_q && !held;
   assign cell_off = wb_req.adr - CELL_BASE;
   assign cell_hit = (cell_off < DIM_Q);

   always_comb
   begin
      status_word             = '0;
      status_word[0]          = status.busy;
      status_word[1]          = status.solved;
      status_word[2]          = status.error;
      status_word[3]          = status.stalled;
      status_word[8 +: IDX_W]  = status.unsolved;
      status_word[16 +: IDX_W] = status.min_idx;
      status_word[24 +: CNT_W] = status.min_poss;
   end

   always_comb
   begin
      rd_data = '0;
      if (cell_hit)
         rd_data[DIM_S-1:0] = out_grid[cell_off];
      else if (wb_req.adr == STATUS_ADDR)
         rd_data = status_word;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack_q <= 1'b0;
         held  <= 1'b0;
         start <= 1'b0;
         clr   <= 1'b0;
      end
      else
      begin
         ack_q <= req_new;
         held  <= wb_req.stb && (held || ack_q);
         start <= req_new && wb_req.we && (wb_req.adr == CTRL_ADDR) && wb_req.dat[0];
         clr   <= req_new && wb_req.we && (wb_req.adr == CTRL_ADDR) && wb_req.dat[1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (req_new && !wb_req.we)
         rd_q <= rd_data;
   end

   // given store, back to all unknown on clr
   always_ff @(posedge clk)
   begin
      if (rst || clr)
         in_grid <= '1;
      else if (req_new && wb_req.we && cell_hit)
         in_grid[cell_off] <= digit_mask(wb_req.dat[CNT_W-1:0]);
   end

   assign wb_rsp = '{ack: ack_q, dat: rd_q};

endmodule

`default_nettype wire

// ==== source/sudoku_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sudoku_top
   import grid_pkg::*;
   import bus_pkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire wb_req_t wb_req,
   output wb_rsp_t      wb_rsp
);

   wire cell_mask_t [DIM_Q-1:0] in_grid;    // givens from the bus
   wire cell_mask_t [DIM_Q-1:0] out_grid;
   wire solver_status_t         status;
   wire                         start;
   wire                         clr;

   sudoku_wb_regs u_regs (
      .clk      (clk),
      .rst      (rst),
      .wb_req   (wb_req),
      .out_grid (out_grid),
      .status   (status),
      .wb_rsp   (wb_rsp),
      .in_grid  (in_grid),
      .start    (start),
      .clr      (clr)
   );

   sudoku_grid u_grid (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .start    (start),
      .in_grid  (in_grid),
      .out_grid (out_grid),
      .status   (status)
   );

endmodule

`default_nettype wire

// ==== tb/sudoku_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sudoku_tb
   import grid_pkg::*;
   import bus_pkg::*;
();

   // about 8 puzzles of ~170 two-cycle transfers plus solver time and a wide margin
   localparam int TIMEOUT_CYCLES = 20000;

   logic         clk = 1'b0;
   logic         rst;
   wb_req_t      wb_req;
   wire wb_rsp_t wb_rsp;

   logic [31:0] seed;
   logic [31:0] st;                  // last status word read
   int          sol   [DIM_Q];
   int          given [DIM_Q];
   cell_mask_t  mdl   [DIM_Q];       // reference grid
   bit          exp_solved;
   bit          exp_error;
   bit          exp_stalled;
   int          exp_unsolved;
   int          exp_min_idx;
   int          exp_min_poss;
   int          errors;
   int          test_errs;
   int          pass_cnt;
   int          fail_cnt;
   int          cycles;

   sudoku_top dut0 (
      .clk    (clk),
      .rst    (rst),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("run timed out after %0d cycles, the DUT stopped answering", cycles);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int rand_below(input int n);
      seed = xorshift(seed);
      return int'(seed % n);
   endfunction

   // same row, column or box and not the cell itself
   function automatic bit is_peer(input int i, input int j);
      int ri;
      int ci;
      int rj;
      int cj;
      ri = i / DIM_S;
      ci = i % DIM_S;
      rj = j / DIM_S;
      cj = j % DIM_S;
      return (i != j) && (ri == rj || ci == cj || (ri/DIM == rj/DIM && ci/DIM == cj/DIM));
   endfunction

   task automatic check_val(input string what, input int got, input int exp);
      if (got != exp)
      begin
         $display("FAIL %0t: %s is 'h%0h, expected 'h%0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == test_errs)
      begin
         pass_cnt++;
         $display("test %s passed", name);
      end
      else
      begin
         fail_cnt++;
         $display("test %s failed with %0d errors", name, errors - test_errs);
      end
   endtask

   task automatic wb_write(input int adr, input int data);
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b1;
      wb_req.adr = adr[ADDR_W-1:0];
      wb_req.dat = data;
      do
         @(negedge clk);
      while (!wb_rsp.ack);
      wb_req.cyc = 1'b0;   // idle cycle follows before the next request
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_read(input int adr, output logic [31:0] data);
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b0;
      wb_req.adr = adr[ADDR_W-1:0];
      do
         @(negedge clk);
      while (!wb_rsp.ack);
      data       = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
   endtask

   task automatic run_solver();
      wb_write(CTRL_ADDR, 1);
      do
         wb_read(STATUS_ADDR, st);
      while (st[0]);
      wb_read(STATUS_ADDR, st);   // hint fields settle a cycle later
   endtask

   task automatic make_puzzle(input int n);
      int perm  [DIM_S];
      int order [DIM_Q];
      int k;
      int t;
      int r;
      int c;
      for (int v = 0; v < DIM_S; v++)
         perm[v] = v + 1;
      for (int v = DIM_S - 1; v > 0; v--)
      begin
         k       = rand_below(v + 1);
         t       = perm[v];
         perm[v] = perm[k];
         perm[k] = t;
      end
      for (int i = 0; i < DIM_Q; i++)
      begin
         r        = i / DIM_S;
         c        = i % DIM_S;
         sol[i]   = perm[(DIM*(r % DIM) + r/DIM + c) % DIM_S];
         order[i] = i;
         given[i] = 0;
      end
      for (int i = DIM_Q - 1; i > 0; i--)
      begin
         k        = rand_below(i + 1);
         t        = order[i];
         order[i] = order[k];
         order[k] = t;
      end
      for (int i = 0; i < n; i++)
         given[order[i]] = sol[order[i]];
   endtask

   task automatic load_puzzle(input bit all_cells);
      for (int i = 0; i < DIM_Q; i++)
      begin
         if (all_cells || given[i] != 0)
            wb_write(CELL_BASE + i, given[i]);
      end
   endtask

   // flags, unsolved count and hint cell of the reference grid
   task automatic expect_status();
      int n;
      bit found;
      exp_error    = 1'b0;
      exp_unsolved = 0;
      exp_min_idx  = 0;
      exp_min_poss = 0;
      for (int i = 0; i < DIM_Q; i++)
      begin
         n = $countones(mdl[i]);
         if (n == 0)
            exp_error = 1'b1;
         if (n != 1)
            exp_unsolved++;
         for (int j = i + 1; j < DIM_Q; j++)
         begin
            if (n == 1 && is_peer(i, j) && mdl[j] == mdl[i])
               exp_error = 1'b1;   // same digit twice in a group
         end
      end
      // smallest count first, lowest index within it
      found = 1'b0;
      for (int p = 2; p <= DIM_S; p++)
      begin
         for (int i = 0; i < DIM_Q; i++)
         begin
            if (!found && $countones(mdl[i]) == p)
            begin
               exp_min_idx  = i;
               exp_min_poss = p;
               found        = 1'b1;
            end
         end
      end
      exp_solved  = (exp_unsolved == 0) && !exp_error;
      exp_stalled = !exp_solved && !exp_error;
   endtask

   // parallel elimination steps until nothing moves
   task automatic build_model();
      cell_mask_t nxt [DIM_Q];
      bit         moved;
      for (int i = 0; i < DIM_Q; i++)
      begin
         if (given[i] == 0)
            mdl[i] = '1;
         else
            mdl[i] = cell_mask_t'(1) << (given[i] - 1);
      end
      moved = 1'b1;
      while (moved)
      begin
         moved = 1'b0;
         for (int i = 0; i < DIM_Q; i++)
         begin
            nxt[i] = mdl[i];
            if ($countones(mdl[i]) != 1)
            begin
               for (int j = 0; j < DIM_Q; j++)
               begin
                  if (is_peer(i, j) && $countones(mdl[j]) == 1)
                     nxt[i] = nxt[i] & ~mdl[j];
               end
            end
         end
         for (int i = 0; i < DIM_Q; i++)
         begin
            if (nxt[i] != mdl[i])
               moved = 1'b1;
            mdl[i] = nxt[i];
         end
      end
      expect_status();
   endtask

   task automatic compare_grid();
      logic [31:0] d;
      for (int i = 0; i < DIM_Q; i++)
      begin
         wb_read(CELL_BASE + i, d);
         check_val($sformatf("cell %0d mask", i), d[DIM_S-1:0], mdl[i]);
      end
   endtask

   task automatic compare_status(input bit idle);
      check_val("busy", st[0], 0);
      check_val("solved", st[1], idle ? 0 : exp_solved);
      check_val("error", st[2], idle ? 0 : exp_error);
      check_val("stalled", st[3], idle ? 0 : exp_stalled);
      check_val("unsolved", st[14:8], exp_unsolved);
      check_val("min_idx", st[22:16], exp_min_idx);
      check_val("min_poss", st[27:24], exp_min_poss);
   endtask

   task automatic check_idle();
      for (int i = 0; i < DIM_Q; i++)
         mdl[i] = '1;
      expect_status();
      compare_grid();
      wb_read(STATUS_ADDR, st);
      compare_status(1'b1);
   endtask

   task automatic check_puzzle(input int n, input bit all_cells);
      make_puzzle(n);
      load_puzzle(all_cells);
      build_model();
      run_solver();
      compare_status(1'b0);
      compare_grid();
   endtask

   initial
   begin
      int r;
      int c;
      int src;
      int c2;
      rst      = 1'b1;
      wb_req   = '0;
      seed     = 32'h00cc_3133;
      errors   = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      cycles   = 0;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      test_errs = errors;
      check_idle();
      finish_test("reset");

      test_errs = errors;
      check_puzzle(40, 1'b1);
      finish_test("givens");

      test_errs = errors;
      check_puzzle(12 + rand_below(7), 1'b1);
      finish_test("sparse");

      // duplicate one given in its own row
      test_errs = errors;
      make_puzzle(30);
      do
         src = rand_below(DIM_Q);
      while (given[src] == 0);
      r  = src / DIM_S;
      c  = src % DIM_S;
      c2 = (c + 1 + rand_below(DIM_S - 1)) % DIM_S;
      given[r*DIM_S + c2] = given[src];
      load_puzzle(1'b1);
      run_solver();
      check_val("error", st[2], 1);
      check_val("solved", st[1], 0);
      finish_test("contradiction");

      // only new givens written so old ones must be gone
      test_errs = errors;
      wb_write(CTRL_ADDR, 2);
      check_idle();
      check_puzzle(35, 1'b0);
      finish_test("clr");

      for (int k = 1; k <= 4; k++)
      begin
         test_errs = errors;
         check_puzzle(17 + rand_below(48), 1'b1);
         finish_test($sformatf("random %0d", k));
      end

      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/grid_pkg.sv
common/bus_pkg.sv
sudoku/sudoku_cell.sv
sudoku/group_checker.sv
sudoku/min_cell_finder.sv
sudoku/sudoku_grid.sv
source/sudoku_wb_regs.sv
source/sudoku_top.sv
tb/sudoku_tb.sv
